// ==== logic/dmaRegPkg.sv ====
package dmaRegPkg;

	// cpu data bus is one byte
	localparam int dataWidth = 8;

	// register map as seen from the cpu
	// channel registers use addresses 0 to 7 with bit 0 picking address or count
	typedef enum logic [3:0]
	{
		chanAddr = 4'd0,
		chanCount = 4'd1,
		// write loads command and read returns status
		cmdStatus = 4'd8,
		modeWrite = 4'd11,
		clearFlipFlop = 4'd12,
		// any address the controller does not decode
		regNone = 4'd15
	} regSelT;

	// transfer type field of the mode register
	typedef enum logic [1:0]
	{
		xferVerify = 2'b00,
		// io to memory
		xferWrite = 2'b01,
		// memory to io
		xferRead = 2'b10
	} xferTypeT;

	// command register bits
	localparam int cmdDisableBit = 2;
	localparam int cmdRotateBit = 4;

endpackage

// ==== logic/dmaCyclePkg.sv ====
package dmaCyclePkg;

	// fixed by the two byte load sequence
	localparam int addrWidth = 16;

	// channel index for up to four channels
	localparam int chanIdxWidth = 2;

	// one hot transfer states
	// bit 4 would be S3 which single transfers skip
	typedef enum logic [5:0]
	{
		SI = 6'b000001,
		SO = 6'b000010,
		S1 = 6'b000100,
		S2 = 6'b001000,
		S4 = 6'b100000
	} stateT;

endpackage

// ==== logic/regAccessIf.sv ====
interface regAccessIf
	import dmaRegPkg::*, dmaCyclePkg::*;
();
	// one cycle access pulses for the channel registers
	logic wrStrobe;
	logic rdStrobe;
	// addressed channel and register half
	logic [chanIdxWidth-1:0] chanSel;
	logic isCount;
	// byte pointer flip-flop value during the access
	logic highByte;
	logic [dataWidth-1:0] wrData;
	// selected byte, combinational
	logic [dataWidth-1:0] rdByte;

	modport cpu (
		output wrStrobe,
		output rdStrobe,
		output chanSel,
		output isCount,
		output highByte,
		output wrData,
		input rdByte
	);

	modport regs (
		input wrStrobe,
		input rdStrobe,
		input chanSel,
		input isCount,
		input highByte,
		input wrData,
		output rdByte
	);

endinterface

// ==== logic/transferIf.sv ====
interface transferIf
	import dmaCyclePkg::*;
();
	// channel owning the bus, held for the whole cycle
	logic [chanIdxWidth-1:0] grantChan;
	// single pulse in S4 to step the counters
	logic advance;
	// current address of the granted channel
	logic [addrWidth-1:0] curAddr;
	// count already zero before this transfer
	logic tcHit;

	modport ctrl (
		output grantChan,
		output advance,
		input curAddr,
		input tcHit
	);

	modport regs (
		input grantChan,
		input advance,
		output curAddr,
		output tcHit
	);

endinterface

// ==== logic/cpuPort.sv ====
module cpuPort
	import dmaRegPkg::*;
#(
	parameter int numChannels = 4
)
(
	input logic busIf,
	input logic rstN,
	input logic csN,
	input logic cpuRdN,
	input logic cpuWrN,
	input logic [3:0] cpuAddr,
	input logic [dataWidth-1:0] dbIn,
	input logic hlda,
	input logic [numChannels-1:0] dreq,
	input logic [numChannels-1:0] tcPulse,
	output logic [dataWidth-1:0] cpuData,
	output logic cmdDisable,
	output logic cmdRotate,
	output xferTypeT xferType [numChannels],
	regAccessIf.cpu regs
);
	// strobe levels from the previous edge
	logic rdLastN;
	logic wrLastN;
	// falling strobe seen this edge
	logic rdHit;
	logic wrHit;
	// access pulses one cycle later
	logic rdPulse;
	logic wrPulse;
	regSelT selReg;
	logic chanAccess;
	logic [numChannels-1:0] tcFlags;
	logic byteFlop;
	logic [dataWidth-1:0] statusByte;

	function automatic regSelT decodeSel(input logic [3:0] addr);
		regSelT sel;
		if (!addr[3])
		begin
			sel = addr[0] ? chanCount : chanAddr;
		end
		else
		begin
			case (addr)
				4'd8: sel = cmdStatus;
				4'd11: sel = modeWrite;
				4'd12: sel = clearFlipFlop;
				default: sel = regNone;
			endcase
		end
		return sel;
	endfunction

	// the bus belongs to someone else while hlda is high
	assign rdHit = !csN && !hlda && !cpuRdN && rdLastN;
	assign wrHit = !csN && !hlda && !cpuWrN && wrLastN;

	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			rdLastN <= 1'b1;
			wrLastN <= 1'b1;
			rdPulse <= 1'b0;
			wrPulse <= 1'b0;
		end
		else
		begin
			rdLastN <= cpuRdN;
			wrLastN <= cpuWrN;
			rdPulse <= rdHit;
			wrPulse <= wrHit;
		end
	end

	// address and data captured with the strobe edge
	always_ff @(posedge busIf)
	begin
		if (rdHit || wrHit)
		begin
			selReg <= decodeSel(cpuAddr);
			regs.chanSel <= cpuAddr[2:1];
			regs.isCount <= cpuAddr[0];
			regs.wrData <= dbIn;
		end
	end

	assign chanAccess = (selReg == chanAddr) || (selReg == chanCount);
	// channel registers only see their own accesses
	assign regs.wrStrobe = wrPulse && chanAccess;
	assign regs.rdStrobe = rdPulse && chanAccess;
	assign regs.highByte = byteFlop;

	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			cmdDisable <= 1'b0;
			cmdRotate <= 1'b0;
			byteFlop <= 1'b0;
			tcFlags <= '0;
			for (int ch = 0; ch < numChannels; ch++)
				xferType[ch] <= xferVerify;
		end
		else
		begin
			// only the disable and rotate bits of the command byte are used
			if (wrPulse && selReg == cmdStatus)
			begin
				cmdDisable <= regs.wrData[cmdDisableBit];
				cmdRotate <= regs.wrData[cmdRotateBit];
			end
			// mode byte carries the channel in bits 1:0 and the type in bits 3:2
			if (wrPulse && selReg == modeWrite && int'(regs.wrData[1:0]) < numChannels)
				xferType[regs.wrData[1:0]] <= xferTypeT'(regs.wrData[3:2]);
			// each channel byte access flips the pointer once
			if (wrPulse && selReg == clearFlipFlop)
				byteFlop <= 1'b0;
			else if ((wrPulse || rdPulse) && chanAccess)
				byteFlop <= !byteFlop;
			// a new terminal count still lands during a status read
			if (rdPulse && selReg == cmdStatus)
				tcFlags <= tcPulse;
			else
				tcFlags <= tcFlags | tcPulse;
		end
	end

	// status has tc flags low and requests high
	always_comb
	begin
		statusByte = '0;
		statusByte[numChannels-1:0] = tcFlags;
		statusByte[4 +: numChannels] = dreq;
	end

	// read buffer keeps the last byte read
	always_ff @(posedge busIf)
	begin
		if (rdPulse)
		begin
			case (selReg)
				chanAddr, chanCount: cpuData <= regs.rdByte;
				cmdStatus: cpuData <= statusByte;
				default: cpuData <= '0;
			endcase
		end
	end

endmodule

// ==== logic/channelRegs.sv ====
module channelRegs
	import dmaRegPkg::*, dmaCyclePkg::*;
#(
	parameter int numChannels = 4
)
(
	input logic busIf,
	input logic rstN,
	regAccessIf.regs regs,
	transferIf.regs xfer
);
	logic [addrWidth-1:0] baseAddr [numChannels];
	logic [addrWidth-1:0] baseCount [numChannels];
	logic [addrWidth-1:0] curAddr [numChannels];
	logic [addrWidth-1:0] curCount [numChannels];
	// word picked for cpu readback
	logic [addrWidth-1:0] selWord;

	// replace one byte of a word
	function automatic logic [addrWidth-1:0] mergeByte(
		input logic [addrWidth-1:0] word,
		input logic upper,
		input logic [dataWidth-1:0] data
	);
		return upper ? {data, word[dataWidth-1:0]} : {word[addrWidth-1:dataWidth], data};
	endfunction

	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int ch = 0; ch < numChannels; ch++)
			begin
				baseAddr[ch] <= '0;
				baseCount[ch] <= '0;
				curAddr[ch] <= '0;
				curCount[ch] <= '0;
			end
		end
		else
		begin
			for (int ch = 0; ch < numChannels; ch++)
			begin
				// current takes the full base word so both halves stay in step
				if (regs.wrStrobe && regs.chanSel == ch)
				begin
					if (regs.isCount)
					begin
						baseCount[ch] <= mergeByte(baseCount[ch], regs.highByte, regs.wrData);
						curCount[ch] <= mergeByte(baseCount[ch], regs.highByte, regs.wrData);
					end
					else
					begin
						baseAddr[ch] <= mergeByte(baseAddr[ch], regs.highByte, regs.wrData);
						curAddr[ch] <= mergeByte(baseAddr[ch], regs.highByte, regs.wrData);
					end
				end
				else if (xfer.advance && xfer.grantChan == ch)
				begin
					curAddr[ch] <= curAddr[ch] + 1'b1;
					curCount[ch] <= curCount[ch] - 1'b1;
				end
			end
		end
	end

	// readback of current registers only
	always_comb
	begin
		selWord = '0;
		if (regs.rdStrobe && int'(regs.chanSel) < numChannels)
			selWord = regs.isCount ? curCount[regs.chanSel] : curAddr[regs.chanSel];
		regs.rdByte = regs.highByte ? selWord[addrWidth-1:dataWidth] : selWord[dataWidth-1:0];
	end

	assign xfer.curAddr = curAddr[xfer.grantChan];
	// zero before the decrement means this is the last transfer
	assign xfer.tcHit = (curCount[xfer.grantChan] == '0);

endmodule

// ==== logic/priorityArbiter.sv ====
module priorityArbiter
	import dmaCyclePkg::*;
#(
	parameter int numChannels = 4
)
(
	input logic busIf,
	input logic rstN,
	input logic [numChannels-1:0] dreq,
	input logic rotate,
	input logic serviced,
	output logic [chanIdxWidth-1:0] winner,
	output logic anyReq
);
	// channel with the highest priority right now
	logic [chanIdxWidth-1:0] topChan;

	// scan from the lowest priority up so the highest match is kept
	always_comb
	begin
		int idx;
		winner = '0;
		for (int k = numChannels - 1; k >= 0; k--)
		begin
			idx = int'(topChan) + k;
			if (idx >= numChannels)
				idx = idx - numChannels;
			if (dreq[idx])
				winner = chanIdxWidth'(idx);
		end
	end

	assign anyReq = |dreq;

	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			topChan <= '0;
		end
		else if (!rotate)
		begin
			// fixed order keeps channel 0 on top
			topChan <= '0;
		end
		else if (serviced)
		begin
			// serviced channel drops to the bottom
			if (int'(winner) == numChannels - 1)
				topChan <= '0;
			else
				topChan <= winner + 1'b1;
		end
	end

endmodule

// ==== logic/timingControl.sv ====
module timingControl
	import dmaRegPkg::*, dmaCyclePkg::*;
#(
	parameter int numChannels = 4
)
(
	input logic busIf,
	input logic rstN,
	input logic hlda,
	input logic anyReq,
	input logic [chanIdxWidth-1:0] winner,
	input logic cmdDisable,
	input xferTypeT xferType [numChannels],
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic [numChannels-1:0] dack,
	output logic iorN,
	output logic iowN,
	output logic memrN,
	output logic memwN,
	output logic [dataWidth-1:0] addrLow,
	output logic [dataWidth-1:0] addrHigh,
	output logic dbOutEn,
	output logic serviced,
	output logic [numChannels-1:0] tcPulse,
	transferIf.ctrl xfer
);
	stateT state;
	stateT nextState;
	// channel latched when leaving SI
	logic [chanIdxWidth-1:0] grant;
	xferTypeT curType;
	// dack stays up from S1 through S4
	logic onBus;

	always_comb
	begin
		nextState = state;
		case (state)
			SI: if (!cmdDisable && anyReq) nextState = SO;
			// wait here for the hold acknowledge
			SO: if (hlda) nextState = S1;
			S1: nextState = S2;
			S2: nextState = S4;
			S4: nextState = SI;
			default: nextState = SI;
		endcase
	end

	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= SI;
			grant <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == SI && nextState == SO)
				grant <= winner;
		end
	end

	assign curType = xferType[grant];
	assign onBus = (state == S1) || (state == S2) || (state == S4);

	// hold request covers everything outside idle
	assign hrq = (state != SI);
	assign aen = (state == S1) || (state == S2);
	assign adstb = (state == S1);
	// high address byte goes out on the data bus for the latch
	assign dbOutEn = (state == S1);

	// strobes only in S2 and verify drives none
	assign iorN = !(state == S2 && curType == xferWrite);
	assign memwN = !(state == S2 && curType == xferWrite);
	assign memrN = !(state == S2 && curType == xferRead);
	assign iowN = !(state == S2 && curType == xferRead);

	assign addrLow = xfer.curAddr[dataWidth-1:0];
	assign addrHigh = xfer.curAddr[addrWidth-1:dataWidth];

	assign xfer.grantChan = grant;
	// counters step at the end of S4
	assign xfer.advance = (state == S4);
	assign serviced = (state == S4);

	always_comb
	begin
		for (int ch = 0; ch < numChannels; ch++)
		begin
			dack[ch] = onBus && (grant == ch);
			tcPulse[ch] = (state == S4) && xfer.tcHit && (grant == ch);
		end
	end

endmodule

// ==== logic/dmaController.sv ====
module dmaController
	import dmaRegPkg::*, dmaCyclePkg::*;
#(
	parameter int numChannels = 4
)
(
	input logic busIf,
	input logic rstN,
	input logic csN,
	input logic cpuRdN,
	input logic cpuWrN,
	input logic [3:0] cpuAddr,
	input logic [dataWidth-1:0] dbIn,
	input logic [numChannels-1:0] dreq,
	input logic hlda,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic [numChannels-1:0] dack,
	output logic iorN,
	output logic iowN,
	output logic memrN,
	output logic memwN,
	output logic [dataWidth-1:0] addrLow,
	output logic [dataWidth-1:0] dbOut,
	output logic dbOutEn
);
	logic cmdDisable;
	logic cmdRotate;
	xferTypeT xferType [numChannels];
	logic [numChannels-1:0] tcPulse;
	logic serviced;
	logic anyReq;
	logic [chanIdxWidth-1:0] winner;
	logic [dataWidth-1:0] cpuData;
	logic [dataWidth-1:0] addrHigh;

	regAccessIf regBus ();
	transferIf xferBus ();

	// cpu side programming and status
	cpuPort #(
		.numChannels(numChannels)
	) u_cpuPort (
		.busIf(busIf),
		.rstN(rstN),
		.csN(csN),
		.cpuRdN(cpuRdN),
		.cpuWrN(cpuWrN),
		.cpuAddr(cpuAddr),
		.dbIn(dbIn),
		.hlda(hlda),
		.dreq(dreq),
		.tcPulse(tcPulse),
		.cpuData(cpuData),
		.cmdDisable(cmdDisable),
		.cmdRotate(cmdRotate),
		.xferType(xferType),
		.regs(regBus.cpu)
	);

	channelRegs #(
		.numChannels(numChannels)
	) u_channelRegs (
		.busIf(busIf),
		.rstN(rstN),
		.regs(regBus.regs),
		.xfer(xferBus.regs)
	);

	// picks which requesting channel gets the bus
	priorityArbiter #(
		.numChannels(numChannels)
	) u_priorityArbiter (
		.busIf(busIf),
		.rstN(rstN),
		.dreq(dreq),
		.rotate(cmdRotate),
		.serviced(serviced),
		.winner(winner),
		.anyReq(anyReq)
	);

	timingControl #(
		.numChannels(numChannels)
	) u_timingControl (
		.busIf(busIf),
		.rstN(rstN),
		.hlda(hlda),
		.anyReq(anyReq),
		.winner(winner),
		.cmdDisable(cmdDisable),
		.xferType(xferType),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.dack(dack),
		.iorN(iorN),
		.iowN(iowN),
		.memrN(memrN),
		.memwN(memwN),
		.addrLow(addrLow),
		.addrHigh(addrHigh),
		.dbOutEn(dbOutEn),
		.serviced(serviced),
		.tcPulse(tcPulse),
		.xfer(xferBus.ctrl)
	);

	// data bus shares the address high byte and cpu readback
	assign dbOut = dbOutEn ? addrHigh : cpuData;

endmodule

// ==== testbench/clockGen.sv ====
module clockGen
#(
	parameter int period = 10,
	parameter int resetCycles = 3
)
(
	output logic busIf,
	output logic rstN
);
	// free running clock, reset held low for the first few edges
	initial
	begin
		busIf = 1'b0;
		rstN = 1'b0;
		fork
			forever #(period / 2) busIf = ~busIf;
			begin
				repeat (resetCycles) @(posedge busIf);
				rstN <= 1'b1;
			end
		join_none
	end

endmodule

// ==== testbench/dmaControllerTb.sv ====
module dmaControllerTb
	import dmaRegPkg::*;
();
	localparam int numChannels = 4;
	// tests need well under a thousand cycles
	localparam int timeoutCycles = 4000;

	logic busIf;
	logic rstN;
	logic csN;
	logic cpuRdN;
	logic cpuWrN;
	logic [3:0] cpuAddr;
	logic [7:0] dbIn;
	logic [numChannels-1:0] dreq;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	logic [numChannels-1:0] dack;
	logic iorN;
	logic iowN;
	logic memrN;
	logic memwN;
	logic [7:0] addrLow;
	logic [7:0] dbOut;
	logic dbOutEn;
	int cycleCount = 0;

	// expected register contents kept alongside the DUT
	logic [15:0] refAddr [numChannels];
	logic [15:0] refCount [numChannels];
	xferTypeT refType [numChannels];

	clockGen #(
		.period(10),
		.resetCycles(3)
	) u_clockGen (
		.busIf(busIf),
		.rstN(rstN)
	);

	dmaController #(
		.numChannels(numChannels)
	) u_dmaController (
		.busIf(busIf),
		.rstN(rstN),
		.csN(csN),
		.cpuRdN(cpuRdN),
		.cpuWrN(cpuWrN),
		.cpuAddr(cpuAddr),
		.dbIn(dbIn),
		.dreq(dreq),
		.hlda(hlda),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.dack(dack),
		.iorN(iorN),
		.iowN(iowN),
		.memrN(memrN),
		.memwN(memwN),
		.addrLow(addrLow),
		.dbOut(dbOut),
		.dbOutEn(dbOutEn)
	);

	// run limit
	always @(posedge busIf)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout after %0d cycles with tests still running", cycleCount);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		assert (cond === 1'b1)
		else
		begin
			$display("error: %s", what);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// strobe pattern {iorN, iowN, memrN, memwN} expected in S2
	function automatic logic [3:0] expectedStrobes(input xferTypeT kind);
		case (kind)
			xferWrite: return 4'b0110;
			xferRead: return 4'b1001;
			default: return 4'b1111;
		endcase
	endfunction

	// one cpu write with the falling strobe seen on the second edge
	task automatic cpuWrite(input logic [3:0] addr, input logic [7:0] data);
		@(posedge busIf);
		csN <= 1'b0;
		cpuWrN <= 1'b0;
		cpuAddr <= addr;
		dbIn <= data;
		@(posedge busIf);
		csN <= 1'b1;
		cpuWrN <= 1'b1;
		// write lands here
		@(posedge busIf);
	endtask

	task automatic cpuRead(input logic [3:0] addr, output logic [7:0] data);
		@(posedge busIf);
		csN <= 1'b0;
		cpuRdN <= 1'b0;
		cpuAddr <= addr;
		@(posedge busIf);
		csN <= 1'b1;
		cpuRdN <= 1'b1;
		@(posedge busIf);
		// read buffer settled by the falling edge
		@(negedge busIf);
		data = dbOut;
	endtask

	task automatic setRequests(input logic [numChannels-1:0] value);
		@(posedge busIf);
		dreq <= value;
	endtask

	task automatic setMode(input int ch, input xferTypeT kind);
		cpuWrite(modeWrite, {4'b0000, kind, 2'(ch)});
		refType[ch] = kind;
	endtask

	// address and count loaded low byte first
	task automatic programChannel(input int ch, input logic [15:0] addr, input logic [15:0] count);
		cpuWrite(clearFlipFlop, 8'h00);
		cpuWrite(4'(ch * 2), addr[7:0]);
		cpuWrite(4'(ch * 2), addr[15:8]);
		cpuWrite(4'(ch * 2 + 1), count[7:0]);
		cpuWrite(4'(ch * 2 + 1), count[15:8]);
		refAddr[ch] = addr;
		refCount[ch] = count;
	endtask

	task automatic verifyChannel(input int ch);
		logic [7:0] lo;
		logic [7:0] hi;
		cpuWrite(clearFlipFlop, 8'h00);
		cpuRead(4'(ch * 2), lo);
		cpuRead(4'(ch * 2), hi);
		checkValue($sformatf("curAddr ch%0d", ch), {hi, lo}, refAddr[ch]);
		cpuRead(4'(ch * 2 + 1), lo);
		cpuRead(4'(ch * 2 + 1), hi);
		checkValue($sformatf("curCount ch%0d", ch), {hi, lo}, refCount[ch]);
	endtask

	// one single transfer for the channel expected to win
	task automatic runTransfer(input int ch, input int holdCycles, input logic dropReq);
		logic [numChannels-1:0] expDack;
		int waitCount;
		expDack = numChannels'(1) << ch;
		waitCount = 0;
		@(negedge busIf);
		while (hrq !== 1'b1)
		begin
			checkTrue(waitCount < 20, "hrq did not rise for a pending request");
			waitCount++;
			@(negedge busIf);
		end
		// controller parks in SO until the hold acknowledge
		repeat (holdCycles)
		begin
			@(negedge busIf);
			checkValue("hrq", hrq, 1'b1);
			checkValue("aen", aen, 1'b0);
			checkValue("adstb", adstb, 1'b0);
			checkValue("dack", dack, '0);
		end
		@(posedge busIf);
		hlda <= 1'b1;
		@(posedge busIf);
		// S1 puts the address out
		@(negedge busIf);
		checkValue("adstb", adstb, 1'b1);
		checkValue("aen", aen, 1'b1);
		checkValue("dack", dack, expDack);
		checkValue("dbOutEn", dbOutEn, 1'b1);
		checkValue("addrLow", addrLow, refAddr[ch][7:0]);
		checkValue("dbOut", dbOut, refAddr[ch][15:8]);
		// S2 strobes follow the mode register
		@(negedge busIf);
		checkValue("adstb", adstb, 1'b0);
		checkValue("aen", aen, 1'b1);
		checkValue("dack", dack, expDack);
		checkValue("strobes", {iorN, iowN, memrN, memwN}, expectedStrobes(refType[ch]));
		// S4 releases the strobes
		@(negedge busIf);
		checkValue("aen", aen, 1'b0);
		checkValue("dack", dack, expDack);
		checkValue("strobes", {iorN, iowN, memrN, memwN}, 4'b1111);
		refAddr[ch] = refAddr[ch] + 16'd1;
		refCount[ch] = refCount[ch] - 16'd1;
		@(posedge busIf);
		hlda <= 1'b0;
		if (dropReq)
			dreq <= '0;
		@(negedge busIf);
		checkValue("hrq", hrq, 1'b0);
		checkValue("dack", dack, '0);
	endtask

	task automatic testReset();
		@(negedge busIf);
		checkValue("hrq", hrq, 1'b0);
		checkValue("aen", aen, 1'b0);
		checkValue("adstb", adstb, 1'b0);
		checkValue("dbOutEn", dbOutEn, 1'b0);
		checkValue("dack", dack, '0);
		checkValue("strobes", {iorN, iowN, memrN, memwN}, 4'b1111);
	endtask

	task automatic testReadback();
		for (int ch = 0; ch < numChannels; ch++)
		begin
			programChannel(ch, 16'($urandom), 16'($urandom));
			verifyChannel(ch);
		end
	endtask

	// clear after an odd access count must land on the low byte again
	task automatic testFlipFlop();
		logic [7:0] first;
		logic [7:0] lo;
		logic [7:0] hi;
		logic [7:0] got;
		first = 8'($urandom);
		lo = 8'($urandom);
		hi = 8'($urandom);
		cpuWrite(clearFlipFlop, 8'h00);
		cpuWrite(4'd0, first);
		cpuWrite(clearFlipFlop, 8'h00);
		cpuWrite(4'd0, lo);
		cpuWrite(4'd0, hi);
		refAddr[0] = {hi, lo};
		cpuWrite(clearFlipFlop, 8'h00);
		cpuRead(4'd0, got);
		cpuWrite(clearFlipFlop, 8'h00);
		cpuRead(4'd0, got);
		checkValue("addr low byte after clear", got, lo);
		cpuRead(4'd0, got);
		checkValue("addr high byte", got, hi);
	endtask

	task automatic testSingleTransfers();
		xferTypeT kinds [numChannels];
		kinds = '{xferWrite, xferRead, xferVerify, xferWrite};
		for (int ch = 0; ch < numChannels; ch++)
		begin
			setMode(ch, kinds[ch]);
			// nonzero count keeps terminal count out of this test
			programChannel(ch, 16'($urandom), {8'($urandom), 8'($urandom) | 8'h01});
			setRequests(numChannels'(1) << ch);
			runTransfer(ch, 3 + ch, 1'b1);
			verifyChannel(ch);
		end
	endtask

	task automatic testTerminalCount();
		logic [7:0] status;
		// flush any old flags
		cpuRead(cmdStatus, status);
		programChannel(1, 16'($urandom), 16'h0000);
		setRequests(4'b0010);
		runTransfer(1, 1, 1'b1);
		cpuRead(cmdStatus, status);
		checkValue("status", status, 8'h02);
		cpuRead(cmdStatus, status);
		checkValue("status", status, 8'h00);
		verifyChannel(1);
	endtask

	task automatic testFixedPriority();
		cpuWrite(cmdStatus, 8'h00);
		setRequests(4'b1111);
		for (int k = 0; k < 4; k++)
			runTransfer(0, 1, k == 3);
	endtask

	// each serviced channel drops to the bottom
	task automatic testRotatingPriority();
		cpuWrite(cmdStatus, 8'(1 << cmdRotateBit));
		setRequests(4'b1111);
		for (int k = 0; k < 4; k++)
			runTransfer(k, 1, k == 3);
		cpuWrite(cmdStatus, 8'h00);
	endtask

	task automatic testDisable();
		logic [7:0] status;
		cpuWrite(cmdStatus, 8'(1 << cmdDisableBit));
		setRequests(4'b0001);
		repeat (20)
		begin
			@(negedge busIf);
			checkValue("hrq", hrq, 1'b0);
		end
		// pending request shows in the upper status bits
		cpuRead(cmdStatus, status);
		checkValue("status requests", status[7:4], 4'b0001);
		setRequests(4'b0000);
		cpuWrite(cmdStatus, 8'h00);
	endtask

	initial
	begin
		csN = 1'b1;
		cpuRdN = 1'b1;
		cpuWrN = 1'b1;
		cpuAddr = 4'd0;
		dbIn = 8'h00;
		dreq = '0;
		hlda = 1'b0;
		void'($urandom(32'h4fc13676));
		@(posedge rstN);
		testReset();
		testReadback();
		testFlipFlop();
		testSingleTransfers();
		testTerminalCount();
		testFixedPriority();
		testRotatingPriority();
		testDisable();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== dmaController.f ====
logic/dmaRegPkg.sv
logic/dmaCyclePkg.sv
logic/regAccessIf.sv
logic/transferIf.sv
logic/cpuPort.sv
logic/channelRegs.sv
logic/priorityArbiter.sv
logic/timingControl.sv
logic/dmaController.sv
testbench/clockGen.sv
testbench/dmaControllerTb.sv
